// ==== cpu_core.f ====
verilog/cpu_pkg.sv
verilog/cpu_fsm.sv
verilog/cpu_fetch.sv
verilog/cpu_decode.sv
verilog/cpu_regfile.sv
verilog/cpu_exec.sv
verilog/cpu_lsu.sv
verilog/cpu_core.sv
sim/tb_cpu_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FILELIST  ?= cpu_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_cpu_core.sv ====
//////////////////////////////
// cpu core testbench
// bus models with random ack delays, program
// built from encoders, reference checks
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;
  import cpu_pkg::*;

  localparam int TIMEOUT_CYC = 4000;  // whole program, worst-case delays
  localparam logic [31:0] SEED = 32'hb1b8_9afb;

  logic   i_clk;
  logic   i_arst_n;
  instr_t i_ibus_rd_data;
  logic   i_ibus_ack;
  word_t  i_dbus_rd_data;
  logic   i_dbus_ack;
  word_t  o_ibus_addr;
  logic   o_ibus_rd_en;
  word_t  o_dbus_addr;
  word_t  o_dbus_wr_data;
  logic   o_dbus_wr_en;
  logic   o_dbus_rd_en;

  instr_t imem [256];
  word_t  dmem [1024];
  word_t  sh   [32];              // reference register values
  word_t  pc;                     // build-time pc
  int     skip_n;                 // instructions jumped over
  int     st_off;
  int     tag;                    // test owning the next entries
  word_t  exp_f [$];
  int     exp_f_tag [$];
  word_t  obs_f [$];
  logic [64:0] exp_d [$];         // {we, addr, data}
  int     exp_d_tag [$];
  logic [64:0] obs_d [$];
  logic [31:0] lfsr;
  int     checks;
  int     test_err [1:6];
  string  test_names [1:6] = '{"reset and fetch order", "alu and lui results",
                               "load and add", "branches and jal",
                               "bus protocol under random acks", "x0 stays zero"};

  cpu_core i_dut (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_ibus_rd_data (i_ibus_rd_data),
    .i_ibus_ack     (i_ibus_ack),
    .i_dbus_rd_data (i_dbus_rd_data),
    .i_dbus_ack     (i_dbus_ack),
    .o_ibus_addr    (o_ibus_addr),
    .o_ibus_rd_en   (o_ibus_rd_en),
    .o_dbus_addr    (o_dbus_addr),
    .o_dbus_wr_data (o_dbus_wr_data),
    .o_dbus_wr_en   (o_dbus_wr_en),
    .o_dbus_rd_en   (o_dbus_rd_en)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois, right shift
  endfunction

  task automatic draw_delay(output int d);
    d = 0;
    for (int i = 0; i < 2; i++) begin
      d = (d << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);  // one step per bit
    end
  endtask

  function automatic word_t fill_word(input word_t a);
    return (a * 32'h9e37_79b1) ^ 32'h6b43_a9b5;
  endfunction

  function automatic word_t isa_alu(input int f3, input bit sub, input word_t a, input word_t b);
    case (f3)
      0:       return sub ? a - b : a + b;
      1:       return a << b[4:0];
      2:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      4:       return a ^ b;
      5:       return a >> b[4:0];
      6:       return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_word(input int t, input string sig, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] t=%0d ns %s is %h, expected %h", $time, sig, got, exp);
      test_err[t]++;
    end
  endtask

  task automatic note_failure(input int t, input string msg);
    $display("error at %0d ns: %s", $time, msg);
    test_err[t]++;
  endtask

  task automatic place_instr(input instr_t ins);
    imem[pc[9:2]] = ins;
    if (skip_n == 0) begin
      exp_f.push_back(pc);  // fetch expected here
      exp_f_tag.push_back(tag);
    end else begin
      skip_n--;
    end
    pc += 4;
  endtask

  task automatic emit_alu(input bit is_imm, input int f3, input bit sub,
                          input int rd, input int rs1, input int src);
    word_t  b;
    instr_t ins;
    b = is_imm ? word_t'(src) : sh[src];
    if (is_imm) ins = {12'(src), 5'(rs1), 3'(f3), 5'(rd), OPC_OP_IMM};
    else        ins = {sub ? 7'h20 : 7'h00, 5'(src), 5'(rs1), 3'(f3), 5'(rd), OPC_OP};
    if (skip_n == 0 && rd != 0) sh[rd] = isa_alu(f3, sub, sh[rs1], b);
    place_instr(ins);
  endtask

  task automatic emit_lui(input int rd, input logic [19:0] hi);
    if (skip_n == 0 && rd != 0) sh[rd] = {hi, 12'b0};
    place_instr({hi, 5'(rd), OPC_LUI});
  endtask

  task automatic emit_lw(input int rd, input int rs1, input int off);
    word_t a;
    a = sh[rs1] + word_t'(off);
    if (skip_n == 0) begin
      exp_d.push_back({1'b0, a, 32'd0});
      exp_d_tag.push_back(tag);
      if (rd != 0) sh[rd] = fill_word(a);  // region never stored to
    end
    place_instr({12'(off), 5'(rs1), 3'b010, 5'(rd), OPC_LOAD});
  endtask

  task automatic store_reg(input int rs2);
    logic [11:0] o;
    o = 12'(st_off);
    if (skip_n == 0) begin
      exp_d.push_back({1'b1, sh[10] + word_t'(st_off), sh[rs2]});  // x10 is store base
      exp_d_tag.push_back(tag);
    end
    place_instr({o[11:5], 5'(rs2), 5'd10, 3'b010, o[4:0], OPC_STORE});
    st_off += 4;
  endtask

  task automatic emit_branch(input bit ne, input int rs1, input int rs2);
    bit taken;
    bit ex;
    taken = (sh[rs1] == sh[rs2]) ^ ne;
    ex    = (skip_n == 0);
    // offset 8 hops over one instruction
    place_instr({1'b0, 6'b0, 5'(rs2), 5'(rs1), {2'b00, ne}, 4'b0100, 1'b0, OPC_BRANCH});
    if (ex && taken) skip_n = 1;
  endtask

  task automatic emit_jal(input int rd, input int nskip);
    logic [20:0] o;
    bit          ex;
    o  = 21'(4 * (nskip + 1));
    ex = (skip_n == 0);
    if (ex && rd != 0) sh[rd] = pc + 4;  // link
    place_instr({o[20], o[10:1], o[11], o[19:12], 5'(rd), OPC_JAL});
    if (ex) skip_n = nskip;
  endtask

  task automatic emit_halt();
    place_instr({20'b0, 5'd0, OPC_JAL});  // jal x0, 0
    exp_f.push_back(pc - 4);              // first refetch of the loop
    exp_f_tag.push_back(4);
  endtask

  task automatic build_program();
    for (int i = 0; i < 256; i++) imem[i] = 32'h0000_0013;
    for (int i = 0; i < 32; i++) sh[i] = '0;
    pc = RESET_VECTOR;
    skip_n = 0;
    st_off = 0;
    tag = 1;
    emit_alu(1, 0, 0, 1, 0, 5);
    emit_alu(1, 0, 0, 2, 0, -3);
    emit_alu(1, 0, 0, 10, 0, 'h100);     // store base
    emit_alu(1, 0, 0, 11, 0, 'h600);     // load base
    tag = 2;
    emit_lui(3, 20'hdead5);
    emit_alu(1, 0, 0, 3, 3, 'h7a1);
    store_reg(3);
    emit_alu(0, 0, 0, 4, 1, 2);  store_reg(4);   // add
    emit_alu(0, 0, 1, 4, 1, 2);  store_reg(4);   // sub
    emit_alu(0, 7, 0, 4, 3, 1);  store_reg(4);
    emit_alu(0, 6, 0, 4, 3, 2);  store_reg(4);
    emit_alu(0, 4, 0, 4, 3, 2);  store_reg(4);
    emit_alu(0, 1, 0, 4, 3, 1);  store_reg(4);   // sll by 5
    emit_alu(0, 5, 0, 4, 3, 1);  store_reg(4);
    emit_alu(0, 2, 0, 4, 2, 1);  store_reg(4);   // slt true
    emit_alu(0, 2, 0, 4, 1, 2);  store_reg(4);   // slt false
    emit_alu(1, 7, 0, 4, 3, 'h0f0);  store_reg(4);
    emit_alu(1, 6, 0, 4, 1, -256);   store_reg(4);
    emit_alu(1, 4, 0, 4, 3, 'h555);  store_reg(4);
    emit_alu(1, 2, 0, 4, 2, -2);     store_reg(4);
    emit_alu(1, 2, 0, 4, 1, 4);      store_reg(4);
    tag = 3;
    emit_lw(5, 11, 8);             store_reg(5);
    emit_alu(1, 0, 0, 6, 5, 'h123);  store_reg(6);
    emit_lw(7, 11, -4);            store_reg(7);
    tag = 4;
    emit_branch(0, 1, 1);  emit_alu(1, 0, 0, 8, 0, 'h7ff);  // beq taken
    emit_branch(1, 1, 2);  emit_alu(1, 0, 0, 8, 8, 1);      // bne taken
    emit_branch(0, 1, 2);  emit_alu(1, 0, 0, 8, 8, 3);      // beq falls through
    emit_branch(1, 1, 1);  emit_alu(1, 0, 0, 8, 8, 4);
    store_reg(8);
    emit_jal(9, 2);
    emit_alu(1, 0, 0, 8, 0, -1);
    emit_alu(1, 0, 0, 9, 0, 1);
    store_reg(9);  store_reg(8);
    tag = 6;
    emit_alu(1, 0, 0, 0, 1, 'h55);  store_reg(0);
    emit_alu(0, 0, 0, 0, 1, 2);
    emit_lw(0, 11, 0);              store_reg(0);
    emit_halt();
  endtask

  // instruction bus slave
  initial begin : ibus_model
    word_t a;
    int    cnt;
    int    dly;
    bit    busy;
    i_ibus_ack     = 1'b0;
    i_ibus_rd_data = '0;
    a    = '0;
    cnt  = 0;
    dly  = 0;
    busy = 1'b0;
    forever begin
      @(negedge i_clk);
      if (i_ibus_ack) begin
        i_ibus_ack <= 1'b0;
        check_word(5, "o_ibus_rd_en", 32'(o_ibus_rd_en), 32'd0);  // drops after ack
      end else if (o_ibus_rd_en) begin
        if (!busy) begin
          busy = 1'b1;
          a    = o_ibus_addr;
          cnt  = 0;
          draw_delay(dly);
        end
        check_word(5, "o_ibus_addr", o_ibus_addr, a);  // held while waiting
        if (cnt == dly) begin
          i_ibus_ack     <= 1'b1;
          i_ibus_rd_data <= imem[a[9:2]];
          obs_f.push_back(a);
          busy = 1'b0;
        end else begin
          cnt++;
        end
      end else if (busy) begin
        note_failure(5, "instruction read strobe dropped before its ack");
        busy = 1'b0;
      end
    end
  end

  // data bus slave, memory preloaded with an address pattern
  initial begin : dbus_model
    word_t a;
    word_t wd;
    bit    we;
    int    cnt;
    int    dly;
    bit    busy;
    for (int i = 0; i < 1024; i++) dmem[i] = fill_word(word_t'(i * 4));
    i_dbus_ack     = 1'b0;
    i_dbus_rd_data = '0;
    a    = '0;
    wd   = '0;
    we   = 1'b0;
    cnt  = 0;
    dly  = 0;
    busy = 1'b0;
    forever begin
      @(negedge i_clk);
      if (o_dbus_wr_en && o_dbus_rd_en) note_failure(5, "data read and write strobes both high");
      if (i_dbus_ack) begin
        i_dbus_ack <= 1'b0;
        check_word(5, "o_dbus_wr_en", 32'(o_dbus_wr_en), 32'd0);
        check_word(5, "o_dbus_rd_en", 32'(o_dbus_rd_en), 32'd0);
      end else if (o_dbus_wr_en || o_dbus_rd_en) begin
        if (!busy) begin
          busy = 1'b1;
          we   = o_dbus_wr_en;
          a    = o_dbus_addr;
          wd   = o_dbus_wr_data;
          cnt  = 0;
          draw_delay(dly);
        end
        check_word(5, "o_dbus_addr", o_dbus_addr, a);
        check_word(5, "o_dbus_wr_en", 32'(o_dbus_wr_en), 32'(we));
        if (we) check_word(5, "o_dbus_wr_data", o_dbus_wr_data, wd);
        if (cnt == dly) begin
          i_dbus_ack <= 1'b1;
          if (we) begin
            dmem[a[11:2]] = wd;
            obs_d.push_back({1'b1, a, wd});
          end else begin
            i_dbus_rd_data <= dmem[a[11:2]];
            obs_d.push_back({1'b0, a, 32'd0});
          end
          busy = 1'b0;
        end else begin
          cnt++;
        end
      end else if (busy) begin
        note_failure(5, "data strobe dropped before its ack");
        busy = 1'b0;
      end
    end
  end

  initial begin : main
    int cyc;
    int passed;
    int errors;
    i_arst_n = 1'b0;
    lfsr     = SEED;
    checks   = 0;
    build_program();
    repeat (10) begin
      @(negedge i_clk);
      check_word(1, "o_ibus_rd_en", 32'(o_ibus_rd_en), 32'd0);
      check_word(1, "o_dbus_wr_en", 32'(o_dbus_wr_en), 32'd0);
      check_word(1, "o_dbus_rd_en", 32'(o_dbus_rd_en), 32'd0);
    end
    i_arst_n <= 1'b1;
    @(negedge i_clk);
    check_word(1, "o_ibus_rd_en", 32'(o_ibus_rd_en), 32'd1);  // first cycle after release
    check_word(1, "o_ibus_addr", o_ibus_addr, RESET_VECTOR);
    cyc = 0;
    while (obs_f.size() < exp_f.size() && cyc < TIMEOUT_CYC) begin
      @(posedge i_clk);  // queues settle at negedge
      cyc++;
    end
    if (obs_f.size() < exp_f.size()) begin
      note_failure(5, "timeout, the core never reached the final jump loop");
    end
    for (int i = 0; i < exp_f.size() && i < obs_f.size(); i++) begin
      check_word(exp_f_tag[i], "o_ibus_addr", obs_f[i], exp_f[i]);
    end
    checks++;
    assert (obs_d.size() == exp_d.size()) else
      note_failure(5, $sformatf("expected %0d data accesses, saw %0d",
                                exp_d.size(), obs_d.size()));
    for (int i = 0; i < exp_d.size() && i < obs_d.size(); i++) begin
      check_word(exp_d_tag[i], "o_dbus_wr_en", 32'(obs_d[i][64]), 32'(exp_d[i][64]));
      check_word(exp_d_tag[i], "o_dbus_addr", obs_d[i][63:32], exp_d[i][63:32]);
      check_word(exp_d_tag[i], "o_dbus_wr_data", obs_d[i][31:0], exp_d[i][31:0]);
    end
    passed = 0;
    errors = 0;
    for (int t = 1; t <= 6; t++) begin
      $display("test %0d %s: %s", t, test_names[t], (test_err[t] == 0) ? "pass" : "fail");
      if (test_err[t] == 0) passed++;
      errors += test_err[t];
    end
    $display("tests passed %0d of 6, checks %0d, errors %0d", passed, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_core.sv ====
//////////////////////////////
// cpu core top
// multicycle rv32i subset with ibus and dbus
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpu_core
  import cpu_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_arst_n,
  input  instr_t i_ibus_rd_data,
  input  logic   i_ibus_ack,
  input  word_t  i_dbus_rd_data,
  input  logic   i_dbus_ack,
  output word_t  o_ibus_addr,
  output logic   o_ibus_rd_en,
  output word_t  o_dbus_addr,
  output word_t  o_dbus_wr_data,
  output logic   o_dbus_wr_en,
  output logic   o_dbus_rd_en
);

  logic      dbus_req;
  logic      en_decode;
  logic      en_exec;
  logic      en_wb;
  word_t     pc_inc;
  instr_t    instr;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;
  alu_op_e   alu_op;
  opb_sel_e  opb_sel;
  wb_sel_e   wb_sel;
  logic      rf_we;
  logic      is_mem;
  logic      is_store;
  logic      is_branch;
  logic      branch_ne;
  logic      jump;
  logic      is_lui;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     result;
  logic      branch_taken;
  word_t     wb_data;

  cpu_fsm u_fsm (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_ibus_ack  (i_ibus_ack),
    .i_dbus_ack  (i_dbus_ack),
    .i_is_mem    (is_mem),
    .o_state     (),               // enables carry the state
    .o_ibus_req  (o_ibus_rd_en),
    .o_dbus_req  (dbus_req),
    .o_en_decode (en_decode),
    .o_en_exec   (en_exec),
    .o_en_wb     (en_wb)
  );

  cpu_fetch u_fetch (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_ibus_ack     (i_ibus_ack),
    .i_ibus_rd_data (i_ibus_rd_data),
    .i_en_wb        (en_wb),
    .i_branch_taken (branch_taken),
    .i_jump         (jump),
    .i_imm          (imm),
    .o_pc           (o_ibus_addr),    // pc drives ibus directly
    .o_pc_inc       (pc_inc),
    .o_instr        (instr)
  );

  cpu_decode u_decode (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_en_decode (en_decode),
    .i_instr     (instr),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (rd),
    .o_imm       (imm),
    .o_alu_op    (alu_op),
    .o_opb_sel   (opb_sel),
    .o_wb_sel    (wb_sel),
    .o_rf_we     (rf_we),
    .o_is_mem    (is_mem),
    .o_is_store  (is_store),
    .o_is_branch (is_branch),
    .o_branch_ne (branch_ne),
    .o_jump      (jump),
    .o_is_lui    (is_lui)
  );

  cpu_regfile u_regfile (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rd       (rd),
    .i_we       (en_wb & rf_we),  // write only in wb state
    .i_wr_data  (wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  cpu_exec u_exec (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_en_exec      (en_exec),
    .i_rs1_data     (rs1_data),
    .i_rs2_data     (rs2_data),
    .i_imm          (imm),
    .i_alu_op       (alu_op),
    .i_opb_sel      (opb_sel),
    .i_is_branch    (is_branch),
    .i_branch_ne    (branch_ne),
    .i_is_lui       (is_lui),
    .o_result       (result),
    .o_branch_taken (branch_taken)
  );

  cpu_lsu u_lsu (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_dbus_req     (dbus_req),
    .i_is_store     (is_store),
    .i_result       (result),
    .i_rs2_data     (rs2_data),
    .i_pc_inc       (pc_inc),
    .i_dbus_rd_data (i_dbus_rd_data),
    .i_dbus_ack     (i_dbus_ack),
    .i_wb_sel       (wb_sel),
    .o_dbus_addr    (o_dbus_addr),
    .o_dbus_wr_data (o_dbus_wr_data),
    .o_dbus_wr_en   (o_dbus_wr_en),
    .o_dbus_rd_en   (o_dbus_rd_en),
    .o_wb_data      (wb_data)
  );

endmodule

`default_nettype wire

// ==== verilog/cpu_lsu.sv ====
//////////////////////////////
// cpu load/store unit
// dbus strobes, load capture, wb mux
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpu_lsu
  import cpu_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_arst_n,
  input  logic    i_dbus_req,      // level from fsm
  input  logic    i_is_store,
  input  word_t   i_result,
  input  word_t   i_rs2_data,
  input  word_t   i_pc_inc,
  input  word_t   i_dbus_rd_data,
  input  logic    i_dbus_ack,
  input  wb_sel_e i_wb_sel,
  output word_t   o_dbus_addr,
  output word_t   o_dbus_wr_data,
  output logic    o_dbus_wr_en,
  output logic    o_dbus_rd_en,
  output word_t   o_wb_data
);

  word_t load_q;

  assign o_dbus_addr    = i_result;    // held by exec register
  assign o_dbus_wr_data = i_rs2_data;
  assign o_dbus_wr_en   = i_dbus_req && i_is_store;
  assign o_dbus_rd_en   = i_dbus_req && !i_is_store;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      load_q <= '0;
    end else if (i_dbus_ack && o_dbus_rd_en) begin
      load_q <= i_dbus_rd_data;  // word only
    end
  end

  always_comb begin
    case (i_wb_sel)
      WB_LOAD: o_wb_data = load_q;
      WB_PC4:  o_wb_data = i_pc_inc;  // jal link
      default: o_wb_data = i_result;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_exec.sv ====
//////////////////////////////
// cpu execute stage
// alu, branch compare, result register
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpu_exec
  import cpu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_arst_n,
  input  logic     i_en_exec,
  input  word_t    i_rs1_data,
  input  word_t    i_rs2_data,
  input  word_t    i_imm,
  input  alu_op_e  i_alu_op,
  input  opb_sel_e i_opb_sel,
  input  logic     i_is_branch,
  input  logic     i_branch_ne,
  input  logic     i_is_lui,
  output word_t    o_result,       // alu value or mem address
  output logic     o_branch_taken
);

  word_t opb;
  word_t alu_out;
  logic  taken;

  assign opb = (i_opb_sel == OPB_IMM) ? i_imm : i_rs2_data;

  always_comb begin
    case (i_alu_op)
      ALU_SUB: alu_out = i_rs1_data - opb;
      ALU_AND: alu_out = i_rs1_data & opb;
      ALU_OR:  alu_out = i_rs1_data | opb;
      ALU_XOR: alu_out = i_rs1_data ^ opb;
      ALU_SLL: alu_out = i_rs1_data << opb[4:0];
      ALU_SRL: alu_out = i_rs1_data >> opb[4:0];
      ALU_SLT: alu_out = {31'b0, $signed(i_rs1_data) < $signed(opb)};
      default: alu_out = i_rs1_data + opb;  // add, also ld/st address
    endcase
  end

  // beq/bne only, equality on rs1 and rs2
  assign taken = i_is_branch && ((i_rs1_data == i_rs2_data) ^ i_branch_ne);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_branch_taken <= 1'b0;
    end else if (i_en_exec) begin
      o_branch_taken <= taken;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_en_exec) begin
      o_result <= i_is_lui ? i_imm : alu_out;  // lui passes u-imm
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_regfile.sv ====
//////////////////////////////
// cpu register file
// 32x32, async read, x0 reads zero
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile
  import cpu_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_arst_n,
  input  reg_addr_t i_rs1,
  input  reg_addr_t i_rs2,
  input  reg_addr_t i_rd,
  input  logic      i_we,       // write-back enable
  input  word_t     i_wr_data,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_wr_data;  // x0 never written
    end
  end

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

endmodule

`default_nettype wire

// ==== verilog/cpu_decode.sv ====
//////////////////////////////
// cpu decode stage
// registered fields, immediates and control selects
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpu_decode
  import cpu_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_arst_n,
  input  logic      i_en_decode,
  input  instr_t    i_instr,
  output reg_addr_t o_rs1,
  output reg_addr_t o_rs2,
  output reg_addr_t o_rd,
  output word_t     o_imm,
  output alu_op_e   o_alu_op,
  output opb_sel_e  o_opb_sel,
  output wb_sel_e   o_wb_sel,
  output logic      o_rf_we,
  output logic      o_is_mem,
  output logic      o_is_store,
  output logic      o_is_branch,
  output logic      o_branch_ne,
  output logic      o_jump,
  output logic      o_is_lui
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_d;
  alu_op_e    alu_op_d;
  opb_sel_e   opb_sel_d;
  wb_sel_e    wb_sel_d;
  logic       rf_we_d;
  logic       is_mem_d;
  logic       is_store_d;
  logic       is_branch_d;
  logic       jump_d;
  logic       is_lui_d;

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];

  function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic sub);
    case (f3)
      3'b000:  return sub ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    imm_d       = {{20{i_instr[31]}}, i_instr[31:20]};  // i-type default
    alu_op_d    = ALU_ADD;
    opb_sel_d   = OPB_IMM;
    wb_sel_d    = WB_ALU;
    rf_we_d     = 1'b0;
    is_mem_d    = 1'b0;
    is_store_d  = 1'b0;
    is_branch_d = 1'b0;
    jump_d      = 1'b0;
    is_lui_d    = 1'b0;
    case (opcode)
      OPC_OP: begin
        opb_sel_d = OPB_RS2;
        alu_op_d  = f3_to_op(funct3, i_instr[30]);
        rf_we_d   = (funct3 != 3'b011);                 // no sltu
      end
      OPC_OP_IMM: begin
        alu_op_d = f3_to_op(funct3, 1'b0);              // imm bit 30 is not sub
        rf_we_d  = (funct3 != 3'b011);
      end
      OPC_LUI: begin
        imm_d    = {i_instr[31:12], 12'b0};
        is_lui_d = 1'b1;
        rf_we_d  = 1'b1;
      end
      OPC_JAL: begin
        imm_d    = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};
        jump_d   = 1'b1;
        wb_sel_d = WB_PC4;                              // link = pc + 4
        rf_we_d  = 1'b1;
      end
      OPC_BRANCH: begin
        imm_d       = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                       i_instr[11:8], 1'b0};
        opb_sel_d   = OPB_RS2;
        is_branch_d = (funct3[2:1] == 2'b00);           // beq, bne only
      end
      OPC_LOAD: begin
        wb_sel_d = WB_LOAD;
        rf_we_d  = (funct3 == 3'b010);                  // lw only
        is_mem_d = (funct3 == 3'b010);
      end
      OPC_STORE: begin
        imm_d      = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
        is_mem_d   = (funct3 == 3'b010);                // sw only
        is_store_d = (funct3 == 3'b010);
      end
      default: ;                                        // unknown runs as nop
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_alu_op    <= ALU_ADD;
      o_opb_sel   <= OPB_RS2;
      o_wb_sel    <= WB_ALU;
      o_rf_we     <= 1'b0;
      o_is_mem    <= 1'b0;
      o_is_store  <= 1'b0;
      o_is_branch <= 1'b0;
      o_branch_ne <= 1'b0;
      o_jump      <= 1'b0;
      o_is_lui    <= 1'b0;
    end else if (i_en_decode) begin
      o_alu_op    <= alu_op_d;
      o_opb_sel   <= opb_sel_d;
      o_wb_sel    <= wb_sel_d;
      o_rf_we     <= rf_we_d;
      o_is_mem    <= is_mem_d;
      o_is_store  <= is_store_d;
      o_is_branch <= is_branch_d;
      o_branch_ne <= funct3[0];  // bne when set
      o_jump      <= jump_d;
      o_is_lui    <= is_lui_d;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_en_decode) begin
      o_rs1 <= i_instr[19:15];
      o_rs2 <= i_instr[24:20];
      o_rd  <= i_instr[11:7];
      o_imm <= imm_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_fetch.sv ====
//////////////////////////////
// cpu fetch stage
// pc, instruction register and next-pc select
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch
  import cpu_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_arst_n,
  input  logic   i_ibus_ack,
  input  instr_t i_ibus_rd_data,
  input  logic   i_en_wb,         // pc moves at write-back
  input  logic   i_branch_taken,
  input  logic   i_jump,
  input  word_t  i_imm,
  output word_t  o_pc,            // also the ibus address
  output word_t  o_pc_inc,
  output instr_t o_instr
);

  assign o_pc_inc = o_pc + word_t'(INSTR_BYTES);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_pc <= RESET_VECTOR;
    end else if (i_en_wb) begin
      o_pc <= (i_branch_taken || i_jump) ? o_pc + i_imm : o_pc_inc;  // redirect or step
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ibus_ack) begin
      o_instr <= i_ibus_rd_data;  // data valid with ack
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_fsm.sv ====
//////////////////////////////
// cpu control fsm
// steps fetch, decode, execute, memory, write-back
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cpu_fsm
  import cpu_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_arst_n,
  input  logic       i_ibus_ack,
  input  logic       i_dbus_ack,
  input  logic       i_is_mem,     // load or store, from decode
  output cpu_state_e o_state,
  output logic       o_ibus_req,   // level, held until ack
  output logic       o_dbus_req,
  output logic       o_en_decode,  // one-cycle enables
  output logic       o_en_exec,
  output logic       o_en_wb
);

  cpu_state_e state_d;

  always_comb begin
    state_d = o_state;
    case (o_state)
      ST_FETCH:  if (i_ibus_ack && o_ibus_req) state_d = ST_DECODE;  // wait on ibus
      ST_DECODE: state_d = ST_EXEC;
      ST_EXEC:   state_d = i_is_mem ? ST_MEM : ST_WB;                // skip mem if alu
      ST_MEM:    if (i_dbus_ack) state_d = ST_WB;                    // wait on dbus
      default:   state_d = ST_FETCH;                                 // wb back to fetch
    endcase
  end

  // requests are flops so strobes stay low through reset
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_state    <= ST_FETCH;
      o_ibus_req <= 1'b0;
      o_dbus_req <= 1'b0;
    end else begin
      o_state    <= state_d;
      o_ibus_req <= (state_d == ST_FETCH);  // rises one cycle after release
      o_dbus_req <= (state_d == ST_MEM);
    end
  end

  assign o_en_decode = (o_state == ST_DECODE);
  assign o_en_exec   = (o_state == ST_EXEC);
  assign o_en_wb     = (o_state == ST_WB);

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
//////////////////////////////
// cpu package
// widths, opcodes, reset vector and control enums
// shared by the multicycle rv32i core
//////////////////////////////
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;      // data or address word
  typedef logic [4:0]  reg_addr_t;  // register index
  typedef logic [31:0] instr_t;     // raw instruction

  localparam word_t RESET_VECTOR = 32'h0000_0000;  // first fetch address
  localparam int    NUM_REGS     = 32;
  localparam int    INSTR_BYTES  = 4;              // pc step, no compressed

  // major opcodes, bits [6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  typedef enum logic [2:0] {
    ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_WB
  } cpu_state_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT
  } alu_op_e;

  typedef enum logic {
    OPB_RS2, OPB_IMM
  } opb_sel_e;

  typedef enum logic [1:0] {
    WB_ALU, WB_LOAD, WB_PC4
  } wb_sel_e;

endpackage

`default_nettype wire
